/* list.f */
g729_pkg.sv
basic_ops.sv
scratch_mem.sv
gain_update_erasure.sv
gain_update_erasure_pipe.sv
gain_update_erasure_sva.sv
tb_gain_update_erasure.sv

/* tb_gain_update_erasure.sv */
`timescale 1ns/100ps

module tb_gain_update_erasure;

	localparam int RESET_CYCLES = 5;
	localparam int DONE_TIMEOUT = 100;
	localparam int IDLE_CHECK_CYCLES = 20;

	typedef logic [g729_pkg::HISTORY_LEN-1:0][15:0] hist_vec_t;

	logic                    clk;
	logic                    arst_n;
	logic                    start;
	logic                    test_sel;
	g729_pkg::test_mem_req_t test_req;
	logic                    done;
	g729_pkg::mem_data_t     scratch_mem_in;

	int                      seed;
	hist_vec_t               model;

	// Words to compare, filled by the stimulus
	g729_pkg::mem_addr_t     chk_addr[$];
	g729_pkg::mem_data_t     chk_exp[$];
	g729_pkg::mem_data_t     chk_act[$];
	event                    compare_ev;

	gain_update_erasure_pipe dut0
	(
		.clk            (clk),
		.arst_n         (arst_n),
		.start          (start),
		.test_sel       (test_sel),
		.test_req       (test_req),
		.done           (done),
		.scratch_mem_in (scratch_mem_in)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2 clk = ~clk;
		end
	end

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic longint clip(input longint v, input longint lo, input longint hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	function automatic hist_vec_t update_history(input hist_vec_t hist);
		longint            sum;
		longint            avg;
		longint            pred;
		g729_pkg::word16_t low;
		hist_vec_t         next;
		int                i;
		sum = 0;
		for (i = 0; i < g729_pkg::HISTORY_LEN; i++)
			sum = clip(sum + longint'(g729_pkg::word16_t'(hist[i])),
				longint'(g729_pkg::WORD32_MIN), longint'(g729_pkg::WORD32_MAX));
		avg = sum >>> 2;
		low = g729_pkg::word16_t'(avg[15:0]);
		pred = clip(longint'(low) + longint'(g729_pkg::PRED_EN_OFFSET),
			longint'(g729_pkg::WORD16_MIN), longint'(g729_pkg::WORD16_MAX));
		if (pred < longint'(g729_pkg::PRED_EN_FLOOR))
			pred = longint'(g729_pkg::PRED_EN_FLOOR);
		next[0] = pred[15:0];
		for (i = 1; i < g729_pkg::HISTORY_LEN; i++)
			next[i] = hist[i-1];
		return next;
	endfunction

	function automatic hist_vec_t random_history();
		hist_vec_t h;
		int        r;
		int        i;
		for (i = 0; i < g729_pkg::HISTORY_LEN; i++)
		begin
			r = $random(seed);
			h[i] = r[15:0];
		end
		return h;
	endfunction

	function automatic g729_pkg::mem_data_t sign_extend(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic g729_pkg::mem_addr_t hist_addr(input int i);
		return g729_pkg::PAST_QUA_EN_ADDR + g729_pkg::mem_addr_t'(i);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Test port access and jobs
	////////////////////////////////////////////////////////////////////////////

	// All tasks start and end just after a falling edge
	task automatic write_word(input g729_pkg::mem_addr_t addr, input g729_pkg::mem_data_t data);
		test_sel = 1'b1;
		test_req.write_addr = addr;
		test_req.write_data = data;
		test_req.write_en = 1'b1;
		@(negedge clk);
		test_req.write_en = 1'b0;
	endtask

	task automatic read_word(input g729_pkg::mem_addr_t addr, output g729_pkg::mem_data_t data);
		test_sel = 1'b1;
		test_req.read_addr = addr;
		@(negedge clk);
		data = scratch_mem_in;
	endtask

	task automatic load_history(input hist_vec_t h);
		int i;
		for (i = 0; i < g729_pkg::HISTORY_LEN; i++)
			write_word(hist_addr(i), sign_extend(h[i]));
	endtask

	task automatic expect_word(input g729_pkg::mem_addr_t addr, input g729_pkg::mem_data_t exp);
		chk_addr.push_back(addr);
		chk_exp.push_back(exp);
	endtask

	task automatic expect_history(input hist_vec_t h);
		int i;
		for (i = 0; i < g729_pkg::HISTORY_LEN; i++)
			expect_word(hist_addr(i), sign_extend(h[i]));
	endtask

	task automatic compare_all();
		g729_pkg::mem_data_t data;
		int                  i;
		for (i = 0; i < chk_addr.size(); i++)
		begin
			read_word(chk_addr[i], data);
			chk_act.push_back(data);
		end
		-> compare_ev;
		@(negedge clk);
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (!done && cycles < DONE_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!done)
		begin
			$display("Timeout: done never came after a start pulse");
			stop_run();
		end
		// Step past the done pulse
		@(negedge clk);
	endtask

	task automatic pulse_start();
		test_sel = 1'b0;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic run_job();
		pulse_start();
		wait_done();
	endtask

	task automatic check_done_low(input int n);
		int i;
		for (i = 0; i < n; i++)
		begin
			@(negedge clk);
			assert (done == 1'b0)
			else
			begin
				$display("FAILED done expected %h actual %h", 1'b0, done);
				stop_run();
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Comparing process
	////////////////////////////////////////////////////////////////////////////

	always @(compare_ev)
	begin
		int i;
		for (i = 0; i < chk_addr.size(); i++)
		begin
			assert (chk_act[i] == chk_exp[i])
			else
			begin
				if (chk_addr[i] >= g729_pkg::PAST_QUA_EN_ADDR &&
					chk_addr[i] < hist_addr(g729_pkg::HISTORY_LEN))
					$display("FAILED past_qua_en[%0d] expected %h actual %h",
						chk_addr[i] - g729_pkg::PAST_QUA_EN_ADDR, chk_exp[i], chk_act[i]);
				else
					$display("FAILED mem[%h] expected %h actual %h",
						chk_addr[i], chk_exp[i], chk_act[i]);
				stop_run();
			end
		end
		chk_addr.delete();
		chk_exp.delete();
		chk_act.delete();
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		hist_vec_t           h;
		g729_pkg::mem_data_t side [4];
		int                  side_off [4];
		int                  i;
		int                  job;
		seed = 6;
		side_off = '{-2, -1, 4, 5};
		arst_n = 1'b0;
		start = 1'b0;
		test_sel = 1'b1;
		test_req = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Quiet after reset
		check_done_low(10);

		// Typical erasures
		for (job = 0; job < 3; job++)
		begin
			h = random_history();
			load_history(h);
			run_job();
			expect_history(update_history(h));
			compare_all();
		end

		// Subtract saturates, then the floor applies
		h = {g729_pkg::HISTORY_LEN{16'h8000}};
		load_history(h);
		run_job();
		expect_history(update_history(h));
		compare_all();

		// Largest history, no clamp
		h = {g729_pkg::HISTORY_LEN{16'h7FFF}};
		load_history(h);
		run_job();
		expect_history(update_history(h));
		compare_all();

		// Back to back jobs on one history
		model = random_history();
		load_history(model);
		for (job = 0; job < 5; job++)
		begin
			run_job();
			model = update_history(model);
			expect_history(model);
			compare_all();
		end

		// Second start inside a job
		h = random_history();
		load_history(h);
		pulse_start();
		repeat (4) @(negedge clk);
		pulse_start();
		wait_done();
		check_done_low(IDLE_CHECK_CYCLES);
		expect_history(update_history(h));
		compare_all();

		// Neighbours of the history stay put
		for (i = 0; i < 4; i++)
		begin
			side[i] = $random(seed);
			write_word(hist_addr(side_off[i]), side[i]);
		end
		h = random_history();
		load_history(h);
		run_job();
		expect_history(update_history(h));
		for (i = 0; i < 4; i++)
			expect_word(hist_addr(side_off[i]), side[i]);
		compare_all();

		if (dut0.u_ctrl.u_sva.fail_count != 0)
		begin
			$display("Bound assertions reported %0d failures", dut0.u_ctrl.u_sva.fail_count);
			$display("Test failed");
			$fatal(1, "Assertion failures seen");
		end
		else
		begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

/* gain_update_erasure_sva.sv */
`timescale 1ns/100ps

module gue_sva
(
	input logic                 clk,
	input logic                 arst_n,
	input logic                 start,
	input logic                 done,
	input logic                 mem_we,
	input g729_pkg::gue_state_t state
);

	// Failures seen, read at the end of the run
	int unsigned fail_count = 0;

	done_single_cycle: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
	else
	begin
		$error("done held high for more than one cycle");
		fail_count++;
	end

	quiet_in_reset: assert property (@(posedge clk) !arst_n |-> (!done && !mem_we))
	else
	begin
		$error("done or mem_we high during reset");
		fail_count++;
	end

	no_write_in_idle: assert property (@(posedge clk) disable iff (!arst_n)
		(state == g729_pkg::IDLE) |-> !mem_we)
	else
	begin
		$error("mem_we high in IDLE");
		fail_count++;
	end

	// Job length is 14 cycles, small margin on top
	done_after_start: assert property (@(posedge clk) disable iff (!arst_n)
		(start && state == g729_pkg::IDLE) |-> ##[1:16] done)
	else
	begin
		$error("done missing after a start taken in IDLE");
		fail_count++;
	end

endmodule

bind gain_update_erasure gue_sva u_sva
(
	.clk    (clk),
	.arst_n (arst_n),
	.start  (start),
	.done   (done),
	.mem_we (mem_we),
	.state  (state)
);

/* gain_update_erasure_pipe.sv */
`timescale 1ns/100ps

module gain_update_erasure_pipe
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    start,
	input  logic                    test_sel,
	input  g729_pkg::test_mem_req_t test_req,
	output logic                    done,
	output g729_pkg::mem_data_t     scratch_mem_in
);

	// Operator operands and results
	g729_pkg::word16_t   add_a;
	g729_pkg::word16_t   add_b;
	g729_pkg::word16_t   add_out;
	g729_pkg::word16_t   sub_a;
	g729_pkg::word16_t   sub_b;
	g729_pkg::word16_t   sub_out;
	g729_pkg::word32_t   l_add_a;
	g729_pkg::word32_t   l_add_b;
	g729_pkg::word32_t   l_add_out;
	g729_pkg::word32_t   l_shr_a;
	g729_pkg::word16_t   l_shr_b;
	g729_pkg::word32_t   l_shr_out;

	// Controller side of the memory
	g729_pkg::mem_addr_t ctrl_waddr;
	g729_pkg::mem_data_t ctrl_wdata;
	logic                ctrl_we;
	g729_pkg::mem_addr_t ctrl_raddr;

	// Memory ports after the test muxes
	g729_pkg::mem_addr_t mem_write_addr;
	g729_pkg::mem_data_t mem_write_data;
	logic                mem_write_en;
	g729_pkg::mem_addr_t mem_read_addr;

	gain_update_erasure u_ctrl
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.done      (done),
		.mem_rdata (scratch_mem_in),
		.mem_raddr (ctrl_raddr),
		.mem_waddr (ctrl_waddr),
		.mem_wdata (ctrl_wdata),
		.mem_we    (ctrl_we),
		.add_a     (add_a),
		.add_b     (add_b),
		.add_out   (add_out),
		.sub_a     (sub_a),
		.sub_b     (sub_b),
		.sub_out   (sub_out),
		.l_add_a   (l_add_a),
		.l_add_b   (l_add_b),
		.l_add_out (l_add_out),
		.l_shr_a   (l_shr_a),
		.l_shr_b   (l_shr_b),
		.l_shr_out (l_shr_out)
	);

	basic_ops u_ops
	(
		.add_a     (add_a),
		.add_b     (add_b),
		.sub_a     (sub_a),
		.sub_b     (sub_b),
		.l_add_a   (l_add_a),
		.l_add_b   (l_add_b),
		.l_shr_a   (l_shr_a),
		.l_shr_b   (l_shr_b),
		.add_out   (add_out),
		.sub_out   (sub_out),
		.l_add_out (l_add_out),
		.l_shr_out (l_shr_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// Test port muxes
	////////////////////////////////////////////////////////////////////////////

	// Write address
	always_comb
	begin
		case (test_sel)
			1'b0:    mem_write_addr = ctrl_waddr;
			default: mem_write_addr = test_req.write_addr;
		endcase
	end

	// Write data
	always_comb
	begin
		case (test_sel)
			1'b0:    mem_write_data = ctrl_wdata;
			default: mem_write_data = test_req.write_data;
		endcase
	end

	// Write enable
	always_comb
	begin
		case (test_sel)
			1'b0:    mem_write_en = ctrl_we;
			default: mem_write_en = test_req.write_en;
		endcase
	end

	// Read address
	always_comb
	begin
		case (test_sel)
			1'b0:    mem_read_addr = ctrl_raddr;
			default: mem_read_addr = test_req.read_addr;
		endcase
	end

	scratch_mem u_mem
	(
		.clk        (clk),
		.write_addr (mem_write_addr),
		.write_data (mem_write_data),
		.write_en   (mem_write_en),
		.read_addr  (mem_read_addr),
		.read_data  (scratch_mem_in)
	);

endmodule

/* gain_update_erasure.sv */
`timescale 1ns/100ps

module gain_update_erasure
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic                start,
	output logic                done,

	// Scratch memory
	input  g729_pkg::mem_data_t mem_rdata,
	output g729_pkg::mem_addr_t mem_raddr,
	output g729_pkg::mem_addr_t mem_waddr,
	output g729_pkg::mem_data_t mem_wdata,
	output logic                mem_we,

	// Shared operators
	output g729_pkg::word16_t   add_a,
	output g729_pkg::word16_t   add_b,
	input  g729_pkg::word16_t   add_out,
	output g729_pkg::word16_t   sub_a,
	output g729_pkg::word16_t   sub_b,
	input  g729_pkg::word16_t   sub_out,
	output g729_pkg::word32_t   l_add_a,
	output g729_pkg::word32_t   l_add_b,
	input  g729_pkg::word32_t   l_add_out,
	output g729_pkg::word32_t   l_shr_a,
	output g729_pkg::word16_t   l_shr_b,
	input  g729_pkg::word32_t   l_shr_out
);

	g729_pkg::gue_state_t state;
	g729_pkg::gue_state_t state_next;
	g729_pkg::hist_idx_t  idx;
	g729_pkg::hist_idx_t  rd_idx;
	g729_pkg::hist_idx_t  wr_idx;

	// Running sum and the new history value
	g729_pkg::word32_t    acc;
	g729_pkg::word16_t    pred_en;

	// History entry as returned by the memory
	g729_pkg::word16_t    hist_word;

	// Write request, registered onto the memory port
	logic                 wr_req;
	g729_pkg::mem_addr_t  wr_addr;
	g729_pkg::mem_data_t  wr_data;

	assign hist_word = g729_pkg::word16_t'(mem_rdata[15:0]);

	// Shift walk reads entry idx-1 and writes entry idx+1
	assign rd_idx = idx - 1'b1;
	assign wr_idx = idx + 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			g729_pkg::IDLE:
			begin
				if (start)
					state_next = g729_pkg::READ;
			end
			g729_pkg::READ:
				state_next = g729_pkg::ACCUM;
			g729_pkg::ACCUM:
			begin
				// Index wraps to zero on the last entry
				if (idx == '0)
					state_next = g729_pkg::SCALE;
			end
			g729_pkg::SCALE:
				state_next = g729_pkg::CLAMP;
			g729_pkg::CLAMP:
				state_next = g729_pkg::SHIFT;
			g729_pkg::SHIFT:
			begin
				if (idx == '0)
					state_next = g729_pkg::WRITE_NEW;
			end
			g729_pkg::WRITE_NEW:
				state_next = g729_pkg::DONE;
			default:
				state_next = g729_pkg::IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory and operator drive
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		mem_raddr = g729_pkg::PAST_QUA_EN_ADDR + g729_pkg::mem_addr_t'(idx);
		wr_req = 1'b0;
		wr_addr = g729_pkg::PAST_QUA_EN_ADDR;
		wr_data = mem_rdata;

		// Clamp test, negative when pred_en is below the floor
		add_a = pred_en;
		add_b = -g729_pkg::PRED_EN_FLOOR;

		// Average minus 4.0
		sub_a = g729_pkg::word16_t'(l_shr_out[15:0]);
		sub_b = -g729_pkg::PRED_EN_OFFSET;

		l_add_a = acc;
		l_add_b = {{16{hist_word[15]}}, hist_word};

		l_shr_a = acc;
		l_shr_b = g729_pkg::AVG_SHIFT;

		case (state)
			g729_pkg::SHIFT:
			begin
				mem_raddr = g729_pkg::PAST_QUA_EN_ADDR + g729_pkg::mem_addr_t'(rd_idx);
				// First pass only reads entry 2
				wr_req = (idx != g729_pkg::hist_idx_t'(g729_pkg::HISTORY_LEN - 1));
				wr_addr = g729_pkg::PAST_QUA_EN_ADDR + g729_pkg::mem_addr_t'(wr_idx);
				wr_data = mem_rdata;
			end
			g729_pkg::WRITE_NEW:
			begin
				wr_req = 1'b1;
				wr_addr = g729_pkg::PAST_QUA_EN_ADDR;
				wr_data = {{16{pred_en[15]}}, pred_en};
			end
			default:
			begin
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= g729_pkg::IDLE;
			idx <= '0;
			mem_we <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			state <= state_next;
			mem_we <= wr_req;
			// Last write lands at the end of DONE
			done <= (state == g729_pkg::DONE);
			case (state)
				g729_pkg::IDLE:
					idx <= '0;
				g729_pkg::READ, g729_pkg::ACCUM:
					idx <= idx + 1'b1;
				g729_pkg::CLAMP:
					idx <= g729_pkg::hist_idx_t'(g729_pkg::HISTORY_LEN - 1);
				g729_pkg::SHIFT:
					idx <= idx - 1'b1;
				default:
				begin
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Datapath registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		mem_waddr <= wr_addr;
		mem_wdata <= wr_data;
		case (state)
			g729_pkg::IDLE:
				acc <= '0;
			g729_pkg::ACCUM:
				acc <= l_add_out;
			g729_pkg::SCALE:
				pred_en <= sub_out;
			g729_pkg::CLAMP:
			begin
				if (add_out < 0)
					pred_en <= g729_pkg::PRED_EN_FLOOR;
			end
			default:
			begin
			end
		endcase
	end

endmodule

/* scratch_mem.sv */
`timescale 1ns/100ps

module scratch_mem
(
	input  logic                clk,
	input  g729_pkg::mem_addr_t write_addr,
	input  g729_pkg::mem_data_t write_data,
	input  logic                write_en,
	input  g729_pkg::mem_addr_t read_addr,
	output g729_pkg::mem_data_t read_data
);

	g729_pkg::mem_data_t mem [g729_pkg::MEM_DEPTH];

	// Write port
	always_ff @(posedge clk)
	begin
		if (write_en)
			mem[write_addr] <= write_data;
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge clk)
	begin
		read_data <= mem[read_addr];
	end

endmodule

/* basic_ops.sv */
`timescale 1ns/100ps

module basic_ops
(
	input  g729_pkg::word16_t add_a,
	input  g729_pkg::word16_t add_b,
	input  g729_pkg::word16_t sub_a,
	input  g729_pkg::word16_t sub_b,
	input  g729_pkg::word32_t l_add_a,
	input  g729_pkg::word32_t l_add_b,
	input  g729_pkg::word32_t l_shr_a,
	input  g729_pkg::word16_t l_shr_b,
	output g729_pkg::word16_t add_out,
	output g729_pkg::word16_t sub_out,
	output g729_pkg::word32_t l_add_out,
	output g729_pkg::word32_t l_shr_out
);

	// One extra bit catches the carry into the sign
	logic signed [16:0] add_wide;
	logic signed [16:0] sub_wide;
	logic signed [32:0] l_add_wide;

	// Left shift path for negative counts
	logic signed [16:0] shl_cnt;
	logic [5:0]         shl_amt;
	logic signed [63:0] shl_wide;

	function automatic g729_pkg::word16_t sat16(input logic signed [16:0] v);
		if (v[16] != v[15])
			return v[16] ? g729_pkg::WORD16_MIN : g729_pkg::WORD16_MAX;
		return v[15:0];
	endfunction

	function automatic g729_pkg::word32_t sat32(input logic signed [32:0] v);
		if (v[32] != v[31])
			return v[32] ? g729_pkg::WORD32_MIN : g729_pkg::WORD32_MAX;
		return v[31:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// 16-bit add and subtract
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		add_wide = add_a + add_b;
		sub_wide = sub_a - sub_b;
		add_out = sat16(add_wide);
		sub_out = sat16(sub_wide);
	end

	////////////////////////////////////////////////////////////////////////////
	// 32-bit add
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		l_add_wide = l_add_a + l_add_b;
		l_add_out = sat32(l_add_wide);
	end

	////////////////////////////////////////////////////////////////////////////
	// 32-bit arithmetic shift right
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Magnitude of a negative count, -32768 included
		shl_cnt = -{l_shr_b[15], l_shr_b};
		// Any count of 32 or more saturates a nonzero value
		shl_amt = (shl_cnt > 17'sd32) ? 6'd32 : shl_cnt[5:0];
		shl_wide = {{32{l_shr_a[31]}}, l_shr_a} << shl_amt;

		if (l_shr_b < 0)
		begin
			if (shl_wide[63:31] != {33{shl_wide[63]}})
				l_shr_out = shl_wide[63] ? g729_pkg::WORD32_MIN : g729_pkg::WORD32_MAX;
			else
				l_shr_out = shl_wide[31:0];
		end
		else if (l_shr_b > 16'sd31)
			l_shr_out = l_shr_a >>> 31;
		else
			l_shr_out = l_shr_a >>> l_shr_b[4:0];
	end

endmodule

/* g729_pkg.sv */
package g729_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Word types
	////////////////////////////////////////////////////////////////////////////

	// Q-format speech word and accumulator
	typedef logic signed [15:0] word16_t;
	typedef logic signed [31:0] word32_t;

	// Scratch memory address and data
	typedef logic [11:0] mem_addr_t;
	typedef logic [31:0] mem_data_t;

	////////////////////////////////////////////////////////////////////////////
	// Sizes and addresses
	////////////////////////////////////////////////////////////////////////////

	localparam int MEM_DEPTH = 4096;

	// Number of past quantized energies kept
	localparam int HISTORY_LEN = 4;

	// Index into the history
	typedef logic [$clog2(HISTORY_LEN)-1:0] hist_idx_t;

	// Entry i lives at base + i
	localparam mem_addr_t PAST_QUA_EN_ADDR = 12'h2A0;

	////////////////////////////////////////////////////////////////////////////
	// Fixed-point constants
	////////////////////////////////////////////////////////////////////////////

	localparam word16_t WORD16_MAX = 16'sh7FFF;
	localparam word16_t WORD16_MIN = 16'sh8000;
	localparam word32_t WORD32_MAX = 32'sh7FFF_FFFF;
	localparam word32_t WORD32_MIN = 32'sh8000_0000;

	// Divide the sum of four entries by four
	localparam word16_t AVG_SHIFT = 16'sd2;

	// 4.0 in Q10, negated
	localparam word16_t PRED_EN_OFFSET = -16'sd4096;

	// Lower bound of the predicted energy, -14.0 in Q10
	localparam word16_t PRED_EN_FLOOR = -16'sd14336;

	////////////////////////////////////////////////////////////////////////////
	// Test port and controller state
	////////////////////////////////////////////////////////////////////////////

	// Test side of both memory ports
	typedef struct packed {
		mem_addr_t write_addr;
		mem_addr_t read_addr;
		mem_data_t write_data;
		logic      write_en;
	} test_mem_req_t;

	typedef enum logic [2:0] {
		IDLE,
		READ,
		ACCUM,
		SCALE,
		CLAMP,
		SHIFT,
		WRITE_NEW,
		DONE
	} gue_state_t;

endpackage
